// ==== compile.f ====
+incdir+include
design/cpuPkg.sv
design/phaseSequencer.sv
design/aluGroupDecoder.sv
design/registerFile.sv
design/aluUnit.sv
design/aluGroupCore.sv
tb/aluGroupCore_tb.sv

// ==== tb/aluGroupCases.txt ====
# P name addr data : preload register addr with data, all values in hex
# I name instr wbAddr wbData flags(ZNCV) : run one instruction, B also strobes while busy
I add0 0401 0 0000 8
P r1 1 7FFF
P r2 2 0001
P r3 3 8000
P r4 4 00F0
P r5 5 1234
P r6 6 FFFF
I add 0412 1 8000 5
I addCarry 0462 6 0000 A
I adc 0852 5 1236 0
I sub 0C23 2 8001 7
I sbc 1040 4 00EF 0
I and 1454 5 0026 0
I or 1853 5 8026 4
I xor 1C55 5 0000 8
I not 2073 7 7FFF 0
I neg 2483 8 8000 7
I movKeeps 0091 9 8000 7
I shl 2810 1 0000 A
I shr 2C40 4 0077 2
I asr 3020 2 C000 6
I rol 3420 2 8001 6
I ror 3840 4 803B 6
I swap 3C04 0 3B80 0
I addU4 0529 2 800A 4
P ra E 0300
P rb F 1122
I addRbU8 0634 F 1156 0
I addRaU8Rb 07AB E AE56 4
B subBusy 0C72 7 FFF5 7

// ==== tb/aluGroupCore_tb.sv ====
// Testbench for the ALU-group core with file-driven cases, a reference model and latency checks
`include "cpu_consts.svh"

module aluGroupCore_tb;

	logic             CLK;
	logic             reset;
	logic             instrStart;
	cpuPkg::word_t    instruction;
	logic             loadEn;
	cpuPkg::regAddr_t loadAddr;
	cpuPkg::word_t    loadData;
	logic             busy;
	logic             wbValid;
	cpuPkg::regAddr_t wbAddr;
	cpuPkg::word_t    wbData;
	cpuPkg::ccFlags_t flags;

	byte           kindQ[$]; // P preload, I instruction, B instruction with a strobe while busy
	string         nameQ[$];
	cpuPkg::word_t f0Q[$];   // instruction, or preload address
	cpuPkg::word_t f1Q[$];   // expected wbAddr, or preload data
	cpuPkg::word_t f2Q[$];
	cpuPkg::word_t f3Q[$];

	cpuPkg::word_t    modelRegs [16]; // reference copy of the register file
	cpuPkg::ccFlags_t modelFlags;
	int valueErrors;
	int otherErrors;
	int cycleCount;
	int cycleLimit; // stays 0 until the cases are loaded

	aluGroupCore aluGroupCore_inst (
		.CLK(CLK), .reset(reset), .instrStart(instrStart), .instruction(instruction),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData), .busy(busy),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData), .flags(flags)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK; // period 4

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic checkWord(input string caseName, input cpuPkg::word_t expected,
			input cpuPkg::word_t actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("[FAIL] %s wbData: expected %h, actual %h", caseName, expected, actual);
		end
	endtask

	task automatic checkAddr(input string caseName, input cpuPkg::regAddr_t expected,
			input cpuPkg::regAddr_t actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("[FAIL] %s wbAddr: expected %h, actual %h", caseName, expected, actual);
		end
	endtask

	task automatic checkFlags(input string caseName, input cpuPkg::ccFlags_t expected,
			input cpuPkg::ccFlags_t actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("[FAIL] %s flags ZNCV: expected %b, actual %b", caseName, expected, actual);
		end
	endtask

	task automatic checkBit(input string caseName, input logic expected, input logic actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("[FAIL] %s: expected %b, actual %b", caseName, expected, actual);
		end
	endtask

	// pull every record out of the case file and skip the lines that start with #
	task automatic readCases();
		int fd;
		int ch;
		int n;
		string name;
		cpuPkg::word_t f0;
		cpuPkg::word_t f1;
		cpuPkg::word_t f2;
		cpuPkg::word_t f3;
		fd = $fopen("tb/aluGroupCases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file tb/aluGroupCases.txt");
			$display("Finished with errors");
			$finish;
		end
		ch = $fgetc(fd);
		while (ch != -1) begin
			if (ch == "#") begin
				while (ch != -1 && ch != "\n") ch = $fgetc(fd); // skip the comment
			end else if (ch == "P" || ch == "I" || ch == "B") begin
				f2 = '0;
				f3 = '0;
				if (ch == "P") n = $fscanf(fd, "%s %h %h", name, f0, f1) + 2;
				else n = $fscanf(fd, "%s %h %h %h %h", name, f0, f1, f2, f3);
				if (n != 5) begin
					otherErrors++;
					$display("a line of the case file is incomplete near record %0d", kindQ.size());
				end
				kindQ.push_back(byte'(ch));
				nameQ.push_back(name);
				f0Q.push_back(f0);
				f1Q.push_back(f1);
				f2Q.push_back(f2);
				f3Q.push_back(f3);
			end
			ch = $fgetc(fd); // whitespace and line ends fall through here
		end
		$fclose(fd);
	endtask

	// works the instruction out from the operation table and the flag rules
	task automatic runModel(input cpuPkg::word_t instr, output cpuPkg::regAddr_t dest,
			output cpuPkg::word_t res, output cpuPkg::ccFlags_t ccOut);
		cpuPkg::aluOp_t   op;
		cpuPkg::argMode_t mode;
		cpuPkg::word_t    a;
		cpuPkg::word_t    b;
		int wide;
		int sa;
		int sb;
		int sres;
		int cin;
		logic c;
		logic v;
		op   = instr[`INSTR_ALUF_HI:`INSTR_ALUF_LO];
		mode = instr[`INSTR_ARGF_HI:`INSTR_ARGF_LO];
		dest = instr[`INSTR_ARGA_HI:`INSTR_ARGA_LO];
		b    = modelRegs[instr[`INSTR_ARGB_HI:`INSTR_ARGB_LO]];
		case (mode)
			`MODE_ALU_REG_U4: b = {12'd0, instr[3:0]};
			`MODE_ALU_REGB_U8: begin
				dest = `REG_RB;
				b    = {8'd0, instr[7:0]};
			end
			`MODE_ALU_REGA_U8RB: begin
				dest = `REG_RA;
				b    = {instr[7:0], modelRegs[`REG_RB][7:0]}; // immediate on top of RB's low byte
			end
			default: ;
		endcase
		a   = modelRegs[dest];
		sa  = $signed(a);
		sb  = $signed(b);
		cin = (op == `ALU_OPX_ADC || op == `ALU_OPX_SBC) ? int'(modelFlags[1]) : 0;
		c   = 1'b0;
		v   = 1'b0;
		res = b;
		case (op)
			`ALU_OPX_ADD, `ALU_OPX_ADC: begin
				wide = int'(a) + int'(b) + cin;
				sres = sa + sb + cin;
				res  = wide[15:0];
				c    = wide > 65535;
				v    = sres > 32767 || sres < -32768; // outside the signed 16-bit range
			end
			`ALU_OPX_SUB, `ALU_OPX_SBC, `ALU_OPX_NEG: begin
				wide = (op == `ALU_OPX_NEG) ? -int'(b) : int'(a) - int'(b) - cin;
				sres = (op == `ALU_OPX_NEG) ? -sb : sa - sb - cin;
				res  = wide[15:0];
				c    = wide < 0; // a borrow was needed
				v    = sres > 32767 || sres < -32768;
			end
			`ALU_OPX_AND:  res = a & b;
			`ALU_OPX_OR:   res = a | b;
			`ALU_OPX_XOR:  res = a ^ b;
			`ALU_OPX_NOT:  res = ~b;
			`ALU_OPX_SHL:  {c, res} = {a, 1'b0};
			`ALU_OPX_SHR:  {res, c} = {1'b0, a};
			`ALU_OPX_ASR:  {res, c} = {a[15], a};
			`ALU_OPX_ROL:  {c, res} = {a[15], a[14:0], a[15]};
			`ALU_OPX_ROR:  {res, c} = {a[0], a};
			`ALU_OPX_SWAP: res = {b[7:0], b[15:8]};
			default: ;
		endcase
		if (op == `ALU_OPX_MOV) ccOut = modelFlags; // MOV never touches the flags
		else ccOut = {res == 16'd0, res[15], c, v};
	endtask

	task automatic preloadRegister(input int idx);
		@(negedge CLK);
		loadEn   = 1'b1;
		loadAddr = f0Q[idx][3:0];
		loadData = f1Q[idx];
		@(negedge CLK);
		loadEn = 1'b0;
		modelRegs[f0Q[idx][3:0]] = f1Q[idx];
	endtask

	// one start strobe and then a wait for wbValid on falling edges, where it is settled
	task automatic runInstruction(input int idx, input bit strobeWhileBusy);
		cpuPkg::regAddr_t mAddr;
		cpuPkg::word_t    mData;
		cpuPkg::ccFlags_t mFlags;
		int cycles;
		runModel(f0Q[idx], mAddr, mData, mFlags);
		if (mAddr !== f1Q[idx][3:0] || mData !== f2Q[idx] || mFlags !== f3Q[idx][3:0]) begin
			otherErrors++;
			$display("case %s: the case file disagrees with the model, which gives r%0d = %h flags %b",
				nameQ[idx], mAddr, mData, mFlags);
		end
		modelRegs[mAddr] = mData;
		modelFlags = mFlags;
		@(negedge CLK);
		instruction = f0Q[idx];
		instrStart  = 1'b1;
		@(negedge CLK);
		instrStart = 1'b0;
		cycles = 1;
		while (wbValid !== 1'b1 && cycles < 12) begin
			@(negedge CLK);
			cycles++;
			if (strobeWhileBusy && cycles == 2) begin
				checkBit({nameQ[idx], " busy"}, 1'b1, busy);
				instrStart = 1'b1; // this one must be ignored
			end else begin
				instrStart = 1'b0;
			end
		end
		if (wbValid !== 1'b1) begin
			otherErrors++;
			$display("case %s: no writeback within 12 cycles of the start strobe", nameQ[idx]);
		end else begin
			if (cycles != 5) begin
				otherErrors++;
				$display("case %s: writeback came %0d cycles after the start strobe, not 5",
					nameQ[idx], cycles);
			end
			checkAddr(nameQ[idx], f1Q[idx][3:0], wbAddr);
			checkWord(nameQ[idx], f2Q[idx], wbData);
			checkFlags(nameQ[idx], f3Q[idx][3:0], flags);
		end
		if (strobeWhileBusy) begin
			// long enough for a held-over strobe to reach a writeback of its own
			repeat (6) begin
				@(negedge CLK);
				if (wbValid === 1'b1) begin
					otherErrors++;
					$display("case %s: the strobe sent while busy caused a second writeback",
						nameQ[idx]);
				end
			end
		end
	endtask

	initial begin
		reset       = 1'b1;
		instrStart  = 1'b0;
		instruction = '0;
		loadEn      = 1'b0;
		loadAddr    = '0;
		loadData    = '0;
		valueErrors = 0;
		otherErrors = 0;
		cycleCount  = 0;
		cycleLimit  = 0;
		modelFlags  = '0;
		for (int i = 0; i < 16; i++) modelRegs[i] = '0;
		readCases();
		cycleLimit = 20 + 8 * kindQ.size();
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		@(negedge CLK);
		checkBit("reset busy", 1'b0, busy);
		checkBit("reset wbValid", 1'b0, wbValid);
		checkFlags("reset", 4'b0000, flags);
		for (int i = 0; i < kindQ.size(); i++) begin
			if (kindQ[i] == "P") preloadRegister(i);
			else runInstruction(i, kindQ[i] == "B");
		end
		$display("error count: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== design/aluGroupCore.sv ====
// ALU-group core: top level tying the phase sequencer, decoder, register file and ALU together
module aluGroupCore (
	input  logic             CLK,
	input  logic             reset,
	input  logic             instrStart,
	input  cpuPkg::word_t    instruction,
	input  logic             loadEn,
	input  cpuPkg::regAddr_t loadAddr,
	input  cpuPkg::word_t    loadData,
	output logic             busy,
	output logic             wbValid,
	output cpuPkg::regAddr_t wbAddr,
	output cpuPkg::word_t    wbData,
	output cpuPkg::ccFlags_t flags
);

	cpuPkg::phase_t       phase;
	cpuPkg::word_t        instrReg;
	cpuPkg::regAAddrSel_t regAAddrSel;
	cpuPkg::regBAddrSel_t regBAddrSel;
	cpuPkg::aluOp_t       aluOp;
	cpuPkg::aluBSrc_t     aluBSrc;
	cpuPkg::regAddr_t     argA;
	cpuPkg::regAddr_t     argB;
	cpuPkg::word_t        operandA;
	cpuPkg::word_t        operandB;
	cpuPkg::word_t        result;
	cpuPkg::regAddr_t     writeAddr;
	logic regAEn;
	logic regBEn;
	logic regAWen;
	logic ccLoad;

	phaseSequencer phaseSequencer_inst (
		.CLK(CLK), .reset(reset), .instrStart(instrStart), .instruction(instruction),
		.phase(phase), .instrReg(instrReg), .busy(busy)
	);

	aluGroupDecoder aluGroupDecoder_inst (
		.CLK(CLK), .reset(reset), .phase(phase), .instrReg(instrReg),
		.regAEn(regAEn), .regBEn(regBEn), .regAWen(regAWen),
		.regAAddrSel(regAAddrSel), .regBAddrSel(regBAddrSel), .aluOp(aluOp),
		.aluBSrc(aluBSrc), .ccLoad(ccLoad), .argA(argA), .argB(argB)
	);

	registerFile registerFile_inst (
		.CLK(CLK), .reset(reset), .regAEn(regAEn), .regBEn(regBEn), .regAWen(regAWen),
		.regAAddrSel(regAAddrSel), .regBAddrSel(regBAddrSel), .argA(argA), .argB(argB),
		.writeData(result), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.operandA(operandA), .operandB(operandB), .writeAddr(writeAddr)
	);

	aluUnit aluUnit_inst (
		.CLK(CLK), .reset(reset), .phase(phase), .aluOp(aluOp), .aluBSrc(aluBSrc),
		.argA(argA), .argB(argB), .operandA(operandA), .operandB(operandB),
		.ccLoad(ccLoad), .result(result), .flags(flags)
	);

	// the writeback port mirrors the register-A write in WRITEBACK
	assign wbValid = regAWen;
	assign wbAddr  = writeAddr;
	assign wbData  = result;

endmodule

// ==== design/aluUnit.sv ====
// ALU unit: selects operand B, runs the sixteen operations and holds the result and flag registers
`include "cpu_consts.svh"

module aluUnit (
	input  logic             CLK,
	input  logic             reset,
	input  cpuPkg::phase_t   phase,
	input  cpuPkg::aluOp_t   aluOp,
	input  cpuPkg::aluBSrc_t aluBSrc,
	input  cpuPkg::regAddr_t argA,
	input  cpuPkg::regAddr_t argB,
	input  cpuPkg::word_t    operandA,
	input  cpuPkg::word_t    operandB,
	input  logic             ccLoad,
	output cpuPkg::word_t    result,
	output cpuPkg::ccFlags_t flags
);

	cpuPkg::word_t    opB;
	cpuPkg::word_t    aluOut;
	cpuPkg::ccFlags_t newFlags;
	logic [16:0] addFull; // 17 bits so bit 16 is the carry
	logic [16:0] subFull; // bit 16 is the borrow
	logic [16:0] negFull;
	logic carryIn;
	logic borrowIn;
	logic cOut;
	logic vOut;

	always_comb begin
		case (aluBSrc)
			`ALUB_SRCX_U4:  opB = {12'd0, argB};
			`ALUB_SRCX_U8:  opB = {8'd0, argA, argB};
			`ALUB_SRCX_U8H: opB = {argA, argB, operandB[7:0]}; // immediate high, RB low
			default:        opB = operandB;
		endcase
	end

	// only ADC and SBC take the stored carry, flags[1] is C
	assign carryIn  = (aluOp == `ALU_OPX_ADC) && flags[1];
	assign borrowIn = (aluOp == `ALU_OPX_SBC) && flags[1];
	assign addFull  = {1'b0, operandA} + {1'b0, opB} + {16'd0, carryIn};
	assign subFull  = {1'b0, operandA} - {1'b0, opB} - {16'd0, borrowIn};
	assign negFull  = 17'd0 - {1'b0, opB};

	always_comb begin
		cOut = 1'b0; // logic ops, NOT and SWAP clear C and V
		vOut = 1'b0;
		case (aluOp)
			`ALU_OPX_ADD, `ALU_OPX_ADC: begin
				aluOut = addFull[15:0];
				cOut   = addFull[16];
				vOut   = (operandA[15] == opB[15]) && (aluOut[15] != operandA[15]);
			end
			`ALU_OPX_SUB, `ALU_OPX_SBC: begin
				aluOut = subFull[15:0];
				cOut   = subFull[16];
				vOut   = (operandA[15] != opB[15]) && (aluOut[15] != operandA[15]);
			end
			`ALU_OPX_NEG: begin
				aluOut = negFull[15:0];
				cOut   = negFull[16];            // borrow whenever B is nonzero
				vOut   = opB[15] && aluOut[15]; // only 0x8000 overflows
			end
			`ALU_OPX_AND:  aluOut = operandA & opB;
			`ALU_OPX_OR:   aluOut = operandA | opB;
			`ALU_OPX_XOR:  aluOut = operandA ^ opB;
			`ALU_OPX_NOT:  aluOut = ~opB;
			`ALU_OPX_SHL: begin
				aluOut = {operandA[14:0], 1'b0};
				cOut   = operandA[15];
			end
			`ALU_OPX_SHR: begin
				aluOut = {1'b0, operandA[15:1]};
				cOut   = operandA[0];
			end
			`ALU_OPX_ASR: begin
				aluOut = {operandA[15], operandA[15:1]}; // sign bit is copied down
				cOut   = operandA[0];
			end
			`ALU_OPX_ROL: begin
				aluOut = {operandA[14:0], operandA[15]};
				cOut   = operandA[15];
			end
			`ALU_OPX_ROR: begin
				aluOut = {operandA[0], operandA[15:1]};
				cOut   = operandA[0];
			end
			`ALU_OPX_SWAP: aluOut = {opB[7:0], opB[15:8]};
			default:       aluOut = opB; // MOV, its flags are never loaded
		endcase
		newFlags = {(aluOut == 16'd0), aluOut[15], cOut, vOut};
	end

	// result is latched at the end of COMMIT and read out during WRITEBACK
	always_ff @(posedge CLK) begin
		if (phase == cpuPkg::COMMIT) result <= aluOut;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			flags <= '0;
		end else if (ccLoad && phase == cpuPkg::COMMIT) begin
			flags <= newFlags;
		end
	end

endmodule

// ==== design/registerFile.sv ====
// Register file: 16 x 16 registers with select resolution, latched read ports and a shared write port
`include "cpu_consts.svh"

module registerFile (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 regAEn,
	input  logic                 regBEn,
	input  logic                 regAWen,
	input  cpuPkg::regAAddrSel_t regAAddrSel,
	input  cpuPkg::regBAddrSel_t regBAddrSel,
	input  cpuPkg::regAddr_t     argA,
	input  cpuPkg::regAddr_t     argB,
	input  cpuPkg::word_t        writeData,
	input  logic                 loadEn,
	input  cpuPkg::regAddr_t     loadAddr,
	input  cpuPkg::word_t        loadData,
	output cpuPkg::word_t        operandA,
	output cpuPkg::word_t        operandB,
	output cpuPkg::regAddr_t     writeAddr
);

	cpuPkg::word_t    regs [16];
	cpuPkg::regAddr_t regAAddr;
	cpuPkg::regAddr_t regBAddr;

	// turn the select codes into real register numbers
	always_comb begin
		case (regAAddrSel)
			`REGA_ADDRX_RA: regAAddr = `REG_RA;
			`REGA_ADDRX_RB: regAAddr = `REG_RB;
			default:        regAAddr = argA;
		endcase
		case (regBAddrSel)
			`REGB_ADDRX_RB: regBAddr = `REG_RB;
			default:        regBAddr = argB;
		endcase
	end

	assign writeAddr = regAAddr; // port A is also the writeback target

	// operands are captured at the end of EXECUTE and held through WRITEBACK
	always_ff @(posedge CLK) begin
		if (regAEn && !regAWen) operandA <= regs[regAAddr];
		if (regBEn && !regAWen) operandB <= regs[regBAddr];
	end

	// the preload strobe stands in for loads, a writeback in the same cycle takes priority
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (regAWen) begin
			regs[regAAddr] <= writeData;
		end else if (loadEn) begin
			regs[loadAddr] <= loadData;
		end
	end

endmodule

// ==== design/aluGroupDecoder.sv ====
// ALU-group decoder that maps instruction fields to phase-timed register, flag and operand controls
`include "cpu_consts.svh"

module aluGroupDecoder (
	input  logic                 CLK,
	input  logic                 reset,
	input  cpuPkg::phase_t       phase,
	input  cpuPkg::word_t        instrReg,
	output logic                 regAEn,
	output logic                 regBEn,
	output logic                 regAWen,
	output cpuPkg::regAAddrSel_t regAAddrSel,
	output cpuPkg::regBAddrSel_t regBAddrSel,
	output cpuPkg::aluOp_t       aluOp,
	output cpuPkg::aluBSrc_t     aluBSrc,
	output logic                 ccLoad,
	output cpuPkg::regAddr_t     argA,
	output cpuPkg::regAddr_t     argB
);

	cpuPkg::argMode_t argMode;
	logic rdB; // instruction reads port B

	assign aluOp   = instrReg[`INSTR_ALUF_HI:`INSTR_ALUF_LO];
	assign argMode = instrReg[`INSTR_ARGF_HI:`INSTR_ARGF_LO];
	assign argA    = instrReg[`INSTR_ARGA_HI:`INSTR_ARGA_LO];
	assign argB    = instrReg[`INSTR_ARGB_HI:`INSTR_ARGB_LO];

	// the argument mode alone picks addresses, the B source and whether port B is read
	always_comb begin
		regAAddrSel = `REGA_ADDRX_ARGA;
		regBAddrSel = `REGB_ADDRX_ARGB;
		aluBSrc     = `ALUB_SRCX_REG_B;
		rdB = 1'b0;
		case (argMode)
			`MODE_ALU_REG_REG: begin
				rdB = 1'b1; // both operands come from ARGA and ARGB
			end
			`MODE_ALU_REG_U4: begin
				aluBSrc = `ALUB_SRCX_U4; // B is the low nibble immediate
			end
			`MODE_ALU_REGB_U8: begin
				regAAddrSel = `REGA_ADDRX_RB; // RB is both source and target
				aluBSrc     = `ALUB_SRCX_U8;
			end
			`MODE_ALU_REGA_U8RB: begin
				regAAddrSel = `REGA_ADDRX_RA;
				regBAddrSel = `REGB_ADDRX_RB; // low byte of RB sits under the immediate
				aluBSrc     = `ALUB_SRCX_U8H;
				rdB = 1'b1;
			end
			default: ;
		endcase
	end

	// enables are registered, so each one is high in the phase after the one that sets it
	always_ff @(posedge CLK) begin
		if (reset) begin
			regAEn  <= 1'b0;
			regBEn  <= 1'b0;
			regAWen <= 1'b0;
			ccLoad  <= 1'b0;
		end else begin
			case (phase)
				cpuPkg::FETCH, cpuPkg::WRITEBACK: begin
					regAEn  <= 1'b0;
					regBEn  <= 1'b0;
					regAWen <= 1'b0;
					ccLoad  <= 1'b0;
				end
				cpuPkg::DECODE: begin
					regAEn <= 1'b1; // every ALU mode reads A, read enables live in EXECUTE
					regBEn <= rdB;
				end
				cpuPkg::EXECUTE: begin
					regAEn <= 1'b0;
					regBEn <= 1'b0;
					ccLoad <= (aluOp != `ALU_OPX_MOV); // MOV keeps the old flags
				end
				cpuPkg::COMMIT: begin
					ccLoad  <= 1'b0;
					regAWen <= 1'b1; // every ALU mode writes back to A in WRITEBACK
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== design/phaseSequencer.sv ====
// Phase sequencer: accepts a start strobe, latches the instruction and steps the phases
module phaseSequencer (
	input  logic           CLK,
	input  logic           reset,
	input  logic           instrStart,
	input  cpuPkg::word_t  instruction,
	output cpuPkg::phase_t phase,
	output cpuPkg::word_t  instrReg,
	output logic           busy
);

	cpuPkg::phase_t nextPhase;

	// a start strobe only counts from IDLE, any strobe during a run is dropped
	always_comb begin
		nextPhase = phase;
		case (phase)
			cpuPkg::IDLE:      if (instrStart) nextPhase = cpuPkg::FETCH;
			cpuPkg::FETCH:     nextPhase = cpuPkg::DECODE;
			cpuPkg::DECODE:    nextPhase = cpuPkg::EXECUTE;
			cpuPkg::EXECUTE:   nextPhase = cpuPkg::COMMIT;
			cpuPkg::COMMIT:    nextPhase = cpuPkg::WRITEBACK;
			cpuPkg::WRITEBACK: nextPhase = cpuPkg::IDLE;
			default:           nextPhase = cpuPkg::IDLE; // recover from an unused encoding
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= cpuPkg::IDLE;
		end else begin
			phase <= nextPhase;
		end
	end

	// the word is captured at the edge closing FETCH so decode sees it from DECODE on
	always_ff @(posedge CLK) begin
		if (phase == cpuPkg::FETCH) begin
			instrReg <= instruction;
		end
	end

	assign busy = (phase != cpuPkg::IDLE); // high from FETCH through WRITEBACK

endmodule

// ==== design/cpuPkg.sv ====
// CPU package holding the shared vector types and the phase enum of the ALU-group slice
package cpuPkg;

	typedef logic [15:0] word_t;     // data word or instruction word
	typedef logic [3:0]  regAddr_t;  // register number, 16 registers
	typedef logic [3:0]  aluOp_t;    // ALUF field
	typedef logic [1:0]  argMode_t;  // ARGF field
	typedef logic [3:0]  ccFlags_t;  // {Z, N, C, V}

	// operand and address select codes, values live in the constants header
	typedef logic [2:0] aluBSrc_t;
	typedef logic [1:0] regAAddrSel_t;
	typedef logic [2:0] regBAddrSel_t;

	// one instruction walks FETCH to WRITEBACK and drops back to IDLE
	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		DECODE,
		EXECUTE,
		COMMIT,
		WRITEBACK
	} phase_t;

endpackage

// ==== include/cpu_consts.svh ====
// CPU constants for the ALU-group slice: instruction fields, mode, select and opcode codes
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// instruction field positions, group field in 15:14 is not checked in this slice
`define INSTR_ALUF_HI 13
`define INSTR_ALUF_LO 10
`define INSTR_ARGF_HI 9
`define INSTR_ARGF_LO 8
`define INSTR_ARGA_HI 7
`define INSTR_ARGA_LO 4
`define INSTR_ARGB_HI 3
`define INSTR_ARGB_LO 0

// ALU argument modes carried in ARGF
`define MODE_ALU_REG_REG   2'd0 // Ra,Rb
`define MODE_ALU_REG_U4    2'd1 // Ra,U4
`define MODE_ALU_REGB_U8   2'd2 // RB,U8
`define MODE_ALU_REGA_U8RB 2'd3 // RA,U8.RB

`define ALUB_SRCX_REG_B 3'd0 // register port B
`define ALUB_SRCX_U4    3'd1 // ARGB zero-extended
`define ALUB_SRCX_U8    3'd2 // ARGA:ARGB zero-extended
`define ALUB_SRCX_U8H   3'd3 // ARGA:ARGB in the high byte, RB low byte below

`define REGA_ADDRX_ARGA 2'd0
`define REGA_ADDRX_RA   2'd1
`define REGA_ADDRX_RB   2'd2
`define REGB_ADDRX_ARGB 3'd0
`define REGB_ADDRX_RB   3'd1

`define REG_RA 4'd14 // fixed accumulator-style registers
`define REG_RB 4'd15

`define ALU_OPX_MOV  4'd0
`define ALU_OPX_ADD  4'd1
`define ALU_OPX_ADC  4'd2
`define ALU_OPX_SUB  4'd3
`define ALU_OPX_SBC  4'd4
`define ALU_OPX_AND  4'd5
`define ALU_OPX_OR   4'd6
`define ALU_OPX_XOR  4'd7
`define ALU_OPX_NOT  4'd8
`define ALU_OPX_NEG  4'd9
`define ALU_OPX_SHL  4'd10
`define ALU_OPX_SHR  4'd11
`define ALU_OPX_ASR  4'd12
`define ALU_OPX_ROL  4'd13
`define ALU_OPX_ROR  4'd14
`define ALU_OPX_SWAP 4'd15

`endif
